//--- source/zap_wb_pkg.sv
// ------------------------------------------------
// Wishbone bus package.
// Widths, bus word types and the cycle-type codes
// used by the memory front end master.
// ------------------------------------------------

package zap_wb_pkg;

        // ------------------------------------------------
        // Widths.
        // ------------------------------------------------

        localparam int WB_ADDR_W = 32;
        localparam int WB_DATA_W = 32;
        localparam int WB_SEL_W  = WB_DATA_W / 8;      // One select per byte lane.

        // Byte address step between two beats of a burst.
        localparam int WB_BYTES_PER_BEAT = WB_SEL_W;

        // ------------------------------------------------
        // Bus word types.
        // ------------------------------------------------

        typedef logic [WB_ADDR_W-1:0] wb_addr_t;
        typedef logic [WB_DATA_W-1:0] wb_data_t;
        typedef logic [WB_SEL_W-1:0]  wb_sel_t;
        typedef logic [2:0]           wb_cti_t;

        // ------------------------------------------------
        // Registered feedback cycle types.
        // ------------------------------------------------

        localparam wb_cti_t CTI_INCR = 3'b010;  // Incrementing burst.
        localparam wb_cti_t CTI_EOB  = 3'b111;  // End of burst.

endpackage

//--- source/zap_req_pkg.sv
// ------------------------------------------------
// Requester package.
// Code and data request payloads, port IDs and
// the fast context switch relocation constants.
// ------------------------------------------------

package zap_req_pkg;

        // Longest code burst. One 64 byte line.
        localparam int MAX_BEATS = 16;

        // FCSE relocation.
        localparam int PID_SHIFT   = 25;
        localparam int RELOC_TOP_W = zap_wb_pkg::WB_ADDR_W - PID_SHIFT;

        typedef logic [$clog2(MAX_BEATS+1)-1:0] beats_t;       // 1 to MAX_BEATS.
        typedef logic [7:0]                     pid_t;

        typedef enum logic
        {
                PORT_CODE = 1'b0,
                PORT_DATA = 1'b1
        } port_e;

        // Code line fill request.
        typedef struct packed
        {
                zap_wb_pkg::wb_addr_t adr;
                beats_t               beats;
        } code_req_t;

        // Single beat load or store.
        typedef struct packed
        {
                zap_wb_pkg::wb_addr_t adr;
                logic                 we;
                zap_wb_pkg::wb_sel_t  sel;
                zap_wb_pkg::wb_data_t wdat;
        } data_req_t;

endpackage

//--- source/zap_arb_if.sv
// ------------------------------------------------
// Arbitration interface.
// Grant and beat control shared by the arbiter,
// the beat counter and the bus multiplexer.
// ------------------------------------------------

interface zap_arb_if
        import zap_req_pkg::*;
();

        logic  grant;           // Bus owned by a transaction.
        port_e port;            // Owner of the bus.
        logic  start;           // First cycle of a transaction.
        logic  beat_ack;        // Acked beat while granted.
        logic  last_beat;       // One beat remains.
        logic  done;            // Transaction complete.
        logic  c_done;
        logic  d_done;

        // Completion split per requester slot.
        assign c_done = done && (port == PORT_CODE);
        assign d_done = done && (port == PORT_DATA);

        modport arbiter
        (
                output grant, port, start, done,
                input  beat_ack, last_beat
        );

        modport counter
        (
                input  start, port, beat_ack,
                output last_beat
        );

        modport mux
        (
                input  grant, port, start, last_beat, done,
                output beat_ack
        );

endinterface

//--- source/zap_req_slot.sv
// ------------------------------------------------
// Request slot.
// Captures one strobed request and holds it until
// the arbiter reports its completion.
// ------------------------------------------------

module zap_req_slot #(
        parameter type payload_t = logic [31:0]
)
(
        input  logic     i_clk,
        input  logic     i_arst_n,

        input  logic     i_stb,         // One cycle request strobe.
        input  payload_t i_payload,
        input  logic     i_done,        // Completion of this slot's request.

        output logic     o_valid,
        output payload_t o_payload
);

// Occupancy flag.
always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
                o_valid <= 1'b0;
        else if (i_stb)
                o_valid <= 1'b1;
        else if (i_done)
                o_valid <= 1'b0;
end

// Payload held for the whole transaction.
always_ff @(posedge i_clk)
begin
        if (i_stb)
                o_payload <= i_payload;
end

// ------------------------------------------------
// Assertions.
// ------------------------------------------------

// One outstanding request per port. A new strobe
// must wait for the done of the previous one.
a_no_strobe_when_full : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_stb |-> !o_valid
) else $error("Request strobed while slot is still full.");

endmodule

//--- source/zap_arb_fsm.sv
// ------------------------------------------------
// Bus arbiter.
// Grants the master to one requester per
// transaction. Alternates under contention.
// ------------------------------------------------

module zap_arb_fsm
        import zap_req_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_arst_n,

        input  logic    i_c_valid,
        input  logic    i_d_valid,

        zap_arb_if.arbiter arb
);

typedef enum logic [1:0]
{
        IDLE,
        BUSY,
        DONE
} state_e;

state_e state_q, state_d;
port_e  port_q;         // Owner of the running transaction.
port_e  last_q;         // Port served by the previous transaction.
port_e  pick;

// Tie goes to the port not served last.
always_comb
begin
        if (i_c_valid && i_d_valid)
                pick = (last_q == PORT_CODE) ? PORT_DATA : PORT_CODE;
        else if (i_d_valid)
                pick = PORT_DATA;
        else
                pick = PORT_CODE;
end

// ------------------------------------------------
// Next state.
// ------------------------------------------------

always_comb
begin
        state_d = state_q;

        case (state_q)
        IDLE:   if (i_c_valid || i_d_valid)
                        state_d = BUSY;
        BUSY:   if (arb.beat_ack && arb.last_beat)
                        state_d = DONE;
        default:        state_d = IDLE;         // DONE lasts one cycle.
        endcase
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                state_q <= IDLE;
                port_q  <= PORT_CODE;
                last_q  <= PORT_DATA;
        end
        else
        begin
                state_q <= state_d;

                if (arb.start)
                        port_q <= pick;

                if (state_q == DONE)
                        last_q <= port_q;
        end
end

assign arb.start = (state_q == IDLE) && (i_c_valid || i_d_valid);
assign arb.port  = (state_q == IDLE) ? pick : port_q;   // Valid with start.
assign arb.grant = (state_q == BUSY);
assign arb.done  = (state_q == DONE);

// ------------------------------------------------
// Assertions.
// ------------------------------------------------

// The owner's request stays pending until done.
a_owner_valid : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (state_q == BUSY) |-> ((port_q == PORT_CODE) ? i_c_valid : i_d_valid)
) else $error("Bus owner's request dropped during a transaction.");

endmodule

//--- source/zap_beat_counter.sv
// ------------------------------------------------
// Beat counter.
// Loads the burst length on start, counts acked
// beats and flags the last one.
// ------------------------------------------------

module zap_beat_counter
        import zap_req_pkg::*;
#(
        parameter int MAX_BEATS_P = MAX_BEATS
)
(
        input  logic    i_clk,
        input  logic    i_arst_n,

        input  beats_t  i_beats,        // Code burst length.

        zap_arb_if.counter arb
);

beats_t count_q;        // Beats still to be acked.
beats_t load_beats;

// Data accesses are always a single beat.
assign load_beats = (arb.port == PORT_CODE) ? i_beats : beats_t'(1);

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
                count_q <= '0;
        else if (arb.start)
                count_q <= load_beats;
        else if (arb.beat_ack && (count_q != '0))
                count_q <= count_q - beats_t'(1);
end

assign arb.last_beat = (count_q == beats_t'(1));

// Burst length must be legal for this build.
a_beats_in_range : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        arb.start |-> (load_beats >= 1) && (int'(load_beats) <= MAX_BEATS_P)
) else $error("Burst length out of range.");

endmodule

//--- source/zap_bus_mux.sv
// ------------------------------------------------
// Bus multiplexer.
// Drives the granted request onto the Wishbone
// master with FCSE relocation and BE-32 swapping,
// and returns read data to its requester.
// ------------------------------------------------

module zap_bus_mux
        import zap_wb_pkg::*;
        import zap_req_pkg::*;
#(
        parameter logic BE_32_ENABLE = 1'b0
)
(
        input  logic      i_clk,
        input  logic      i_arst_n,

        input  code_req_t i_code,
        input  data_req_t i_data,
        input  pid_t      i_pid,

        zap_arb_if.mux    arb,

        output logic      o_wb_cyc,
        output logic      o_wb_stb,
        output logic      o_wb_we,
        output wb_addr_t  o_wb_adr,
        output wb_data_t  o_wb_dat,
        output wb_sel_t   o_wb_sel,
        output wb_cti_t   o_wb_cti,
        input  logic      i_wb_ack,
        input  wb_data_t  i_wb_dat,

        output wb_data_t  o_c_rdat,
        output logic      o_c_rvalid,
        output wb_data_t  o_d_rdat,
        output logic      o_d_rvalid
);

// Process ID relocation of the low 32 MB.
function automatic wb_addr_t relocate(input wb_addr_t adr, input pid_t pid);
        wb_addr_t offset;
        offset = wb_addr_t'(pid) << PID_SHIFT;
        if ((pid != '0) && (adr[WB_ADDR_W-1 -: RELOC_TOP_W] == '0))
                return adr + offset;
        return adr;
endfunction

wb_addr_t start_adr;
wb_sel_t  sel_rev;
wb_data_t rdat_rev;
wb_sel_t  data_sel;
wb_data_t data_rdat;
logic     rd_beat;

assign start_adr = (arb.port == PORT_CODE) ? {i_code.adr[WB_ADDR_W-1:2], 2'b00} : i_data.adr;
assign sel_rev   = {<<{i_data.sel}};
assign rdat_rev  = {<<8{i_wb_dat}};
assign data_sel  = BE_32_ENABLE ? sel_rev : i_data.sel;       // Lane order flips.
assign data_rdat = BE_32_ENABLE ? rdat_rev : i_wb_dat;
assign rd_beat   = arb.beat_ack && !o_wb_we;

assign arb.beat_ack = i_wb_ack && arb.grant;
assign o_wb_cti     = (o_wb_cyc && !arb.last_beat) ? CTI_INCR : CTI_EOB;

// ------------------------------------------------
// Bus control.
// ------------------------------------------------

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_we  <= 1'b0;
        end
        else if (arb.start)
        begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                o_wb_we  <= (arb.port == PORT_DATA) && i_data.we;
        end
        else if (arb.beat_ack && arb.last_beat)
        begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_we  <= 1'b0;
        end
end

// Address, select and write data.
always_ff @(posedge i_clk)
begin
        if (arb.start)
        begin
                o_wb_adr <= relocate(start_adr, i_pid);
                o_wb_sel <= (arb.port == PORT_DATA) ? data_sel : '1;
                o_wb_dat <= i_data.wdat;
        end
        else if (arb.beat_ack)
                o_wb_adr <= o_wb_adr + wb_addr_t'(WB_BYTES_PER_BEAT);
end

// ------------------------------------------------
// Read return.
// ------------------------------------------------

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                o_c_rvalid <= 1'b0;
                o_d_rvalid <= 1'b0;
        end
        else
        begin
                o_c_rvalid <= rd_beat && (arb.port == PORT_CODE);
                o_d_rvalid <= rd_beat && (arb.port == PORT_DATA);
        end
end

always_ff @(posedge i_clk)
begin
        if (rd_beat && (arb.port == PORT_CODE))
                o_c_rdat <= i_wb_dat;           // Code is never swapped.
        if (rd_beat && (arb.port == PORT_DATA))
                o_d_rdat <= data_rdat;
end

// The cycle must be closed once the arbiter signals done.
a_cyc_closed_on_done : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        arb.done |-> !o_wb_cyc
) else $error("Bus cycle still open at transaction done.");

endmodule

//--- source/zap_mem_frontend.sv
// ------------------------------------------------
// Memory front end.
// Merges a code burst port and a data port onto a
// single Wishbone master. Holds one request slot
// per port, an arbiter, a beat counter and the
// bus datapath.
// ------------------------------------------------

module zap_mem_frontend
        import zap_wb_pkg::*;
        import zap_req_pkg::*;
#(
        parameter logic BE_32_ENABLE = 1'b0,
        parameter int   MAX_BEATS_P  = MAX_BEATS
)
(
        input  logic     i_clk,
        input  logic     i_arst_n,

        // Code port.
        input  logic     i_c_stb,
        input  wb_addr_t i_c_adr,
        input  beats_t   i_c_beats,
        output wb_data_t o_c_rdat,
        output logic     o_c_rvalid,
        output logic     o_c_done,

        // Data port.
        input  logic     i_d_stb,
        input  wb_addr_t i_d_adr,
        input  logic     i_d_we,
        input  wb_sel_t  i_d_sel,
        input  wb_data_t i_d_wdat,
        output wb_data_t o_d_rdat,
        output logic     o_d_rvalid,
        output logic     o_d_done,

        input  pid_t     i_pid,         // FCSE process ID.

        // Wishbone master.
        output logic     o_wb_cyc,
        output logic     o_wb_stb,
        output logic     o_wb_we,
        output wb_addr_t o_wb_adr,
        output wb_data_t o_wb_dat,
        output wb_sel_t  o_wb_sel,
        output wb_cti_t  o_wb_cti,
        input  logic     i_wb_ack,
        input  wb_data_t i_wb_dat
);

code_req_t c_req, c_held;
data_req_t d_req, d_held;
logic      c_valid, d_valid;

zap_arb_if arb ();

assign c_req    = '{adr: i_c_adr, beats: i_c_beats};
assign d_req    = '{adr: i_d_adr, we: i_d_we, sel: i_d_sel, wdat: i_d_wdat};
assign o_c_done = arb.c_done;
assign o_d_done = arb.d_done;

zap_req_slot #(.payload_t(code_req_t)) u_code_slot (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_stb     (i_c_stb),
        .i_payload (c_req),
        .i_done    (arb.c_done),
        .o_valid   (c_valid),
        .o_payload (c_held)
);

zap_req_slot #(.payload_t(data_req_t)) u_data_slot (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_stb     (i_d_stb),
        .i_payload (d_req),
        .i_done    (arb.d_done),
        .o_valid   (d_valid),
        .o_payload (d_held)
);

zap_arb_fsm u_arb_fsm (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_c_valid (c_valid),
        .i_d_valid (d_valid),
        .arb       (arb.arbiter)
);

zap_beat_counter #(.MAX_BEATS_P(MAX_BEATS_P)) u_beat_counter (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_beats   (c_held.beats),
        .arb       (arb.counter)
);

zap_bus_mux #(.BE_32_ENABLE(BE_32_ENABLE)) u_bus_mux (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_code     (c_held),
        .i_data     (d_held),
        .i_pid      (i_pid),
        .arb        (arb.mux),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_stb   (o_wb_stb),
        .o_wb_we    (o_wb_we),
        .o_wb_adr   (o_wb_adr),
        .o_wb_dat   (o_wb_dat),
        .o_wb_sel   (o_wb_sel),
        .o_wb_cti   (o_wb_cti),
        .i_wb_ack   (i_wb_ack),
        .i_wb_dat   (i_wb_dat),
        .o_c_rdat   (o_c_rdat),
        .o_c_rvalid (o_c_rvalid),
        .o_d_rdat   (o_d_rdat),
        .o_d_rvalid (o_d_rvalid)
);

endmodule

//--- dv/zap_wb_slave_model.sv
// ------------------------------------------------
// Wishbone slave model.
// Computed memory image, 0 to 3 random wait states
// per beat from a Galois LFSR, and a write log.
// ------------------------------------------------

module zap_wb_slave_model
        import zap_wb_pkg::*;
#(
        parameter logic [31:0] SEED = 32'd79294
)
(
        input  logic     i_clk,
        input  logic     i_arst_n,

        input  logic     i_wb_cyc,
        input  logic     i_wb_stb,
        input  logic     i_wb_we,
        input  wb_addr_t i_wb_adr,
        input  wb_data_t i_wb_dat,
        input  wb_sel_t  i_wb_sel,
        output logic     o_wb_ack,
        output wb_data_t o_wb_dat,

        // Last write seen, plus a running count.
        output int       o_wr_count,
        output wb_addr_t o_wr_adr,
        output wb_data_t o_wr_dat,
        output wb_sel_t  o_wr_sel
);

timeunit 1ns;
timeprecision 100ps;

logic [31:0] lfsr;
logic [31:0] lfsr_next;
logic [1:0]  wait_left;         // Wait states before the ack.
logic        busy;              // Beat accepted, wait count drawn.

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0);
endfunction

// Each word holds its word address XOR a fixed pattern.
function automatic wb_data_t mem_word(input wb_addr_t adr);
        return {2'b00, adr[31:2]} ^ 32'hA5A5_5A5A;
endfunction

assign lfsr_next = lfsr_step(lfsr);

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                lfsr       <= SEED;
                wait_left  <= 2'd0;
                busy       <= 1'b0;
                o_wb_ack   <= 1'b0;
                o_wb_dat   <= '0;
                o_wr_count <= 0;
                o_wr_adr   <= '0;
                o_wr_dat   <= '0;
                o_wr_sel   <= '0;
        end
        else
        begin
                o_wb_ack <= 1'b0;       // Ack lasts one cycle.
                if (i_wb_cyc && i_wb_stb && !o_wb_ack)
                begin
                        if (!busy)
                        begin
                                // Two bits, two LFSR steps.
                                wait_left <= {lfsr[0], lfsr_next[0]};
                                lfsr      <= lfsr_step(lfsr_next);
                                busy      <= 1'b1;
                        end
                        else if (wait_left == 2'd0)
                        begin
                                o_wb_ack <= 1'b1;
                                busy     <= 1'b0;
                                o_wb_dat <= mem_word(i_wb_adr);
                                if (i_wb_we)
                                begin
                                        o_wr_count <= o_wr_count + 1;
                                        o_wr_adr   <= i_wb_adr;
                                        o_wr_dat   <= i_wb_dat;
                                        o_wr_sel   <= i_wb_sel;
                                end
                        end
                        else
                                wait_left <= wait_left - 2'd1;
                end
        end
end

endmodule

//--- dv/zap_mem_frontend_tb.sv
// ------------------------------------------------
// Memory front end testbench.
// Reads the tests file, strobes the code and data
// ports, checks each bus beat, read word and write
// against the expected values, then reports.
// ------------------------------------------------

module zap_mem_frontend_tb
        import zap_wb_pkg::*;
        import zap_req_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int FIELDS    = 10;
localparam int MAX_TESTS = 32;

// ------------------------------------------------
// Column order of the tests file.
// ------------------------------------------------

localparam int F_OP      = 0;
localparam int F_ADR     = 1;
localparam int F_BEATS   = 2;
localparam int F_SEL     = 3;
localparam int F_WDAT    = 4;
localparam int F_PID     = 5;
localparam int F_PAR     = 6;   // Strobe together with the next test.
localparam int F_EXP_ADR = 7;
localparam int F_EXP_SEL = 8;
localparam int F_EXP_RD  = 9;   // First read word.

localparam int OP_CODE_RD = 0;
localparam int OP_DATA_RD = 1;
localparam int OP_DATA_WR = 2;

logic     clk;
logic     arst_n;
logic     c_stb;
wb_addr_t c_adr;
beats_t   c_beats;
wb_data_t c_rdat;
logic     c_rvalid;
logic     c_done;
logic     d_stb;
wb_addr_t d_adr;
logic     d_we;
wb_sel_t  d_sel;
wb_data_t d_wdat;
wb_data_t d_rdat;
logic     d_rvalid;
logic     d_done;
pid_t     pid;
logic     wb_cyc;
logic     wb_stb;
logic     wb_we;
wb_addr_t wb_adr;
wb_data_t wb_dat_m;
wb_sel_t  wb_sel;
wb_cti_t  wb_cti;
logic     wb_ack;
wb_data_t wb_dat_s;
int       wr_count;
wb_addr_t wr_adr;
wb_data_t wr_dat;
wb_sel_t  wr_sel;

logic [31:0] tests [MAX_TESTS*FIELDS];
int          ntests;
int          checks;
int          errors;
int          cycles;
int          limit;
int          prev_wr_count;
port_e       last_port;         // Port of the latest done.

// Beats and read words seen since the previous done.
wb_addr_t beat_adr[$];
wb_cti_t  beat_cti[$];
wb_sel_t  beat_sel[$];
logic     beat_we[$];
wb_data_t beat_dat[$];
wb_data_t c_words[$];
wb_data_t d_words[$];

zap_mem_frontend #(.BE_32_ENABLE(1'b1)) dut (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_c_stb    (c_stb),
        .i_c_adr    (c_adr),
        .i_c_beats  (c_beats),
        .o_c_rdat   (c_rdat),
        .o_c_rvalid (c_rvalid),
        .o_c_done   (c_done),
        .i_d_stb    (d_stb),
        .i_d_adr    (d_adr),
        .i_d_we     (d_we),
        .i_d_sel    (d_sel),
        .i_d_wdat   (d_wdat),
        .o_d_rdat   (d_rdat),
        .o_d_rvalid (d_rvalid),
        .o_d_done   (d_done),
        .i_pid      (pid),
        .o_wb_cyc   (wb_cyc),
        .o_wb_stb   (wb_stb),
        .o_wb_we    (wb_we),
        .o_wb_adr   (wb_adr),
        .o_wb_dat   (wb_dat_m),
        .o_wb_sel   (wb_sel),
        .o_wb_cti   (wb_cti),
        .i_wb_ack   (wb_ack),
        .i_wb_dat   (wb_dat_s)
);

zap_wb_slave_model u_slave (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_adr   (wb_adr),
        .i_wb_dat   (wb_dat_m),
        .i_wb_sel   (wb_sel),
        .o_wb_ack   (wb_ack),
        .o_wb_dat   (wb_dat_s),
        .o_wr_count (wr_count),
        .o_wr_adr   (wr_adr),
        .o_wr_dat   (wr_dat),
        .o_wr_sel   (wr_sel)
);

always #10 clk = ~clk;

// Run limit from the number of tests.
always @(posedge clk)
begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
                $display("Timeout after %0d cycles with requests still open.", cycles);
                $display("Simulation FAILED");
                $finish;
        end
end

// ------------------------------------------------
// Helpers.
// ------------------------------------------------

function automatic logic [31:0] field(input int t, input int f);
        return tests[t*FIELDS + f];
endfunction

// Memory image of the slave.
function automatic wb_data_t mem_word(input wb_addr_t adr);
        return {2'b00, adr[31:2]} ^ 32'hA5A5_5A5A;
endfunction

function automatic string test_name(input int t);
        case (field(t, F_OP))
        OP_CODE_RD: return $sformatf("test%0d_code_rd", t);
        OP_DATA_RD: return $sformatf("test%0d_data_rd", t);
        default:    return $sformatf("test%0d_data_wr", t);
        endcase
endfunction

function automatic port_e port_of(input int t);
        return (field(t, F_OP) == OP_CODE_RD) ? PORT_CODE : PORT_DATA;
endfunction

task automatic check_value(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
                errors++;
                $display("error %s %s: expected %h, actual %h", name, what, exp, act);
        end
endtask

task automatic drive_test(input int t);
        pid <= pid_t'(field(t, F_PID));
        if (field(t, F_OP) == OP_CODE_RD)
        begin
                c_stb   <= 1'b1;
                c_adr   <= field(t, F_ADR);
                c_beats <= beats_t'(field(t, F_BEATS));
        end
        else
        begin
                d_stb  <= 1'b1;
                d_adr  <= field(t, F_ADR);
                d_we   <= (field(t, F_OP) == OP_DATA_WR);
                d_sel  <= wb_sel_t'(field(t, F_SEL));
                d_wdat <= field(t, F_WDAT);
        end
endtask

// Compares one finished transaction with its test line.
task automatic check_txn(input int t);
        string       name;
        int          n;
        int          k;
        logic [31:0] op;
        wb_addr_t    exp_adr;
        wb_data_t    exp_word;
        wb_cti_t     exp_cti;
        wb_data_t    words[$];

        name    = test_name(t);
        op      = field(t, F_OP);
        n       = (op == OP_CODE_RD) ? int'(field(t, F_BEATS)) : 1;
        exp_adr = field(t, F_EXP_ADR);

        check_value(name, "bus beats", n, beat_adr.size());
        for (k = 0; k < beat_adr.size() && k < n; k++)
        begin
                exp_cti = (k == n - 1) ? CTI_EOB : CTI_INCR;
                check_value(name, $sformatf("adr beat %0d", k), exp_adr + 4 * k, beat_adr[k]);
                check_value(name, $sformatf("cti beat %0d", k), exp_cti, beat_cti[k]);
                check_value(name, $sformatf("sel beat %0d", k), field(t, F_EXP_SEL), beat_sel[k]);
                check_value(name, $sformatf("we beat %0d", k), op == OP_DATA_WR, beat_we[k]);
                if (op == OP_DATA_WR)
                        check_value(name, "bus data", field(t, F_WDAT), beat_dat[k]);
        end

        if (op == OP_DATA_WR)
        begin
                check_value(name, "write log count", prev_wr_count + 1, wr_count);
                check_value(name, "write log adr", exp_adr, wr_adr);
                check_value(name, "write log data", field(t, F_WDAT), wr_dat);
                check_value(name, "write log sel", field(t, F_EXP_SEL), wr_sel);
                prev_wr_count = wr_count;
        end
        else
        begin
                if (op == OP_CODE_RD)
                        words = c_words;
                else
                        words = d_words;
                check_value(name, "read words", n, words.size());
                for (k = 0; k < words.size() && k < n; k++)
                begin
                        exp_word = (k == 0) ? field(t, F_EXP_RD) : mem_word(exp_adr + 4 * k);
                        check_value(name, $sformatf("read word %0d", k), exp_word, words[k]);
                end
        end

        beat_adr.delete();
        beat_cti.delete();
        beat_sel.delete();
        beat_we.delete();
        beat_dat.delete();
        if (op == OP_CODE_RD)
                c_words.delete();
        else
                d_words.delete();
endtask

// Watches the bus and ports until every request is done.
task automatic run_until_done(input int t, input logic pair);
        int    pending;
        int    code_t;
        int    data_t;
        int    idx;
        port_e first;
        port_e done_port;

        pending = pair ? 2 : 1;
        code_t  = -1;
        data_t  = -1;
        first   = (last_port == PORT_CODE) ? PORT_DATA : PORT_CODE;
        for (idx = t; idx < t + pending; idx++)
        begin
                if (port_of(idx) == PORT_CODE)
                        code_t = idx;
                else
                        data_t = idx;
        end

        while (pending > 0)
        begin
                @(negedge clk);
                if (wb_cyc && wb_stb && wb_ack)
                begin
                        beat_adr.push_back(wb_adr);
                        beat_cti.push_back(wb_cti);
                        beat_sel.push_back(wb_sel);
                        beat_we.push_back(wb_we);
                        beat_dat.push_back(wb_dat_m);
                end
                if (c_rvalid)
                        c_words.push_back(c_rdat);
                if (d_rvalid)
                        d_words.push_back(d_rdat);
                if (c_done || d_done)
                begin
                        done_port = c_done ? PORT_CODE : PORT_DATA;
                        idx       = c_done ? code_t : data_t;
                        if (idx < 0)
                        begin
                                errors++;
                                $display("Done strobe from an idle port, test %0d.", t);
                        end
                        else
                        begin
                                if (pair && pending == 2)
                                        check_value(test_name(idx), "first port", first, done_port);
                                if (wb_cyc)
                                begin
                                        errors++;
                                        $display("Bus cycle of %s still open at its done.",
                                                 test_name(idx));
                                end
                                check_txn(idx);
                        end
                        last_port = done_port;
                        pending--;
                end
        end
endtask

// Bus and ports stay quiet after reset.
task automatic check_reset_idle();
        repeat (8)
        begin
                @(negedge clk);
                check_value("reset_idle", "cyc", 1'b0, wb_cyc);
                check_value("reset_idle", "stb", 1'b0, wb_stb);
                check_value("reset_idle", "cti", CTI_EOB, wb_cti);
                check_value("reset_idle", "rvalid", 2'b00, {c_rvalid, d_rvalid});
                check_value("reset_idle", "done", 2'b00, {c_done, d_done});
        end
endtask

// ------------------------------------------------
// Main sequence.
// ------------------------------------------------

initial
begin
        int   i;
        int   t;
        logic pair;

        clk           = 1'b0;
        arst_n        = 1'b0;
        c_stb         = 1'b0;
        c_adr         = '0;
        c_beats       = '0;
        d_stb         = 1'b0;
        d_adr         = '0;
        d_we          = 1'b0;
        d_sel         = '0;
        d_wdat        = '0;
        pid           = '0;
        checks        = 0;
        errors        = 0;
        cycles        = 0;
        prev_wr_count = 0;
        last_port     = PORT_DATA;

        for (i = 0; i < MAX_TESTS * FIELDS; i++)
                tests[i] = '1;
        $readmemh("dv/zap_frontend_tests.txt", tests);
        ntests = 0;
        while (ntests < MAX_TESTS && field(ntests, F_OP) != 32'hFFFF_FFFF)
                ntests++;
        if (ntests == 0)
        begin
                errors++;
                $display("No tests were read from the tests file.");
        end
        limit = ntests * (MAX_BEATS + 2) * 8;

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        check_reset_idle();

        t = 0;
        while (t < ntests)
        begin
                pair = (field(t, F_PAR) != 0) && (t + 1 < ntests);
                @(posedge clk);
                drive_test(t);
                if (pair)
                        drive_test(t + 1);
                @(posedge clk);
                c_stb <= 1'b0;
                d_stb <= 1'b0;
                run_until_done(t, pair);
                t = t + (pair ? 2 : 1);
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", ntests, checks, errors);
        if (errors == 0)
                $display("Simulation PASSED");
        else
                $display("Simulation FAILED");
        $finish;
end

endmodule

//--- project.f
source/zap_wb_pkg.sv
source/zap_req_pkg.sv
source/zap_arb_if.sv
source/zap_req_slot.sv
source/zap_arb_fsm.sv
source/zap_beat_counter.sv
source/zap_bus_mux.sv
source/zap_mem_frontend.sv
dv/zap_wb_slave_model.sv
dv/zap_mem_frontend_tb.sv

//--- dv/zap_frontend_tests.txt
// op adr beats sel wdat pid par exp_adr exp_sel exp_rdat
// op 0 code read, 1 data read, 2 data write. par 1 strobes with the next line.
0 00001003 04 0 00000000 00 0 00001000 f a5a55e5a
2 00002000 01 3 deadbeef 00 0 00002000 c 00000000
1 00003004 01 f 00000000 00 0 00003004 f 5b56a5a5
0 00003004 01 0 00000000 00 0 00003004 f a5a5565b
// Relocation by process ID.
1 00000100 01 f 00000000 03 0 06000100 f 1a5a25a4
0 04000008 02 0 00000000 03 0 04000008 f a4a55a58
2 00000040 01 1 12345678 03 0 06000040 8 00000000
0 00000800 08 0 00000000 02 0 04000800 f a4a5585a
// Contention, data goes first after a code transaction.
0 00004000 10 0 00000000 00 1 00004000 f a5a54a5a
2 00005000 01 f cafef00d 00 0 00005000 f 00000000
1 00006008 01 f 00000000 00 0 00006008 f 5842a5a5
// Contention, code goes first after a data transaction.
0 00007002 03 0 00000000 00 1 00007000 f a5a5465a
1 00007000 01 f 00000000 00 0 00007000 f 5a46a5a5
// End marker.
ffffffff
